//--- lc4_pkg.sv
`default_nettype none

package lc4_pkg;

   localparam int LC4_WORD_W = 16;
   localparam int LC4_REG_W  = 3;

   typedef logic [LC4_WORD_W-1:0] lc4_word_t;
   typedef logic [LC4_REG_W-1:0]  lc4_reg_t;

   // primary opcode, instruction bits 15..12
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } lc4_opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM,
      ALU_ADDR
   } lc4_alu_op_e;

   localparam lc4_word_t LC4_RESET_PC   = 16'h8200;
   localparam int        LC4_NUM_REGS   = 8;
   localparam int        LC4_PIPE_DEPTH = 4;

   // instruction fields
   localparam int OPC_MSB   = 15;
   localparam int OPC_LSB   = 12;
   localparam int RD_MSB    = 11;
   localparam int RD_LSB    = 9;
   localparam int RS_MSB    = 8;
   localparam int RS_LSB    = 6;
   localparam int SUBOP_MSB = 5;
   localparam int SUBOP_LSB = 3;
   localparam int RT_MSB    = 2;
   localparam int RT_LSB    = 0;
   localparam int IMM9_W    = 9;
   localparam int OFF6_W    = 6;

   // sub-op codes for ARITH and LOGIC
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

endpackage

`default_nettype wire

//--- lc4_stage_if.sv
`default_nettype none

// one instruction in flight between two adjacent stages
interface lc4_stage_if
   import lc4_pkg::*;
();

   lc4_word_t   pc;
   lc4_word_t   insn;
   lc4_opcode_e op;
   lc4_alu_op_e alu_op;
   lc4_reg_t    wsel;
   logic        rf_we;
   logic        is_load;
   logic        is_store;
   lc4_word_t   rs_data;
   lc4_word_t   rt_data;
   lc4_word_t   result;

   modport src (
      output pc, insn, op, alu_op, wsel, rf_we,
      output is_load, is_store, rs_data, rt_data, result
   );

   modport dst (
      input pc, insn, op, alu_op, wsel, rf_we,
      input is_load, is_store, rs_data, rt_data, result
   );

endinterface

`default_nettype wire

//--- lc4_fetch.sv
`default_nettype none

module lc4_fetch
   import lc4_pkg::*;
#(
   parameter lc4_word_t P_RESET_PC = LC4_RESET_PC
) (
   input  wire        gwe,
   input  wire        i_rst_n,
   input  lc4_word_t  i_cur_insn,
   output lc4_word_t  o_cur_pc,
   lc4_stage_if.src   f2d
);

   lc4_word_t pc;

   // no branches, so the pc just counts up
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc       <= P_RESET_PC;
         f2d.pc   <= '0;
         f2d.insn <= '0;
      end else begin
         pc       <= pc + 16'd1;
         f2d.pc   <= pc;
         f2d.insn <= i_cur_insn;
      end
   end

   assign o_cur_pc = pc;

   // nothing decoded yet
   assign f2d.op       = OP_NOP;
   assign f2d.alu_op   = ALU_ADD;
   assign f2d.wsel     = '0;
   assign f2d.rf_we    = 1'b0;
   assign f2d.is_load  = 1'b0;
   assign f2d.is_store = 1'b0;
   assign f2d.rs_data  = '0;
   assign f2d.rt_data  = '0;
   assign f2d.result   = '0;

endmodule

`default_nettype wire

//--- lc4_decode.sv
`default_nettype none

module lc4_decode
   import lc4_pkg::*;
(
   input  wire        gwe,
   input  wire        i_rst_n,
   lc4_stage_if.dst   f2d,
   lc4_stage_if.src   d2x,
   output lc4_reg_t   o_rs_sel,
   output lc4_reg_t   o_rt_sel,
   input  lc4_word_t  i_rs_data,
   input  lc4_word_t  i_rt_data
);

   logic [3:0]  opc;
   logic [2:0]  subop;
   lc4_opcode_e op;
   lc4_alu_op_e alu_op;
   logic        rf_we;
   logic        is_load;
   logic        is_store;

   assign opc   = f2d.insn[OPC_MSB:OPC_LSB];
   assign subop = f2d.insn[SUBOP_MSB:SUBOP_LSB];

   assign o_rs_sel = f2d.insn[RS_MSB:RS_LSB];
   // STR reads the stored register from the rd field
   assign o_rt_sel = (opc == OP_STR) ? f2d.insn[RD_MSB:RD_LSB] : f2d.insn[RT_MSB:RT_LSB];

   always_comb begin
      op       = OP_NOP;
      alu_op   = ALU_ADD;
      is_load  = 1'b0;
      is_store = 1'b0;
      case (opc)
         OP_ARITH: begin
            if (subop == SUB_ADD) begin
               op = OP_ARITH;
            end else if (subop == SUB_SUB) begin
               op     = OP_ARITH;
               alu_op = ALU_SUB;
            end
         end
         OP_LOGIC: begin
            if (subop == SUB_AND || subop == SUB_OR || subop == SUB_XOR) begin
               op = OP_LOGIC;
            end
            if (subop == SUB_AND) begin
               alu_op = ALU_AND;
            end else if (subop == SUB_OR) begin
               alu_op = ALU_OR;
            end else begin
               alu_op = ALU_XOR;
            end
         end
         OP_LDR: begin
            op      = OP_LDR;
            alu_op  = ALU_ADDR;
            is_load = 1'b1;
         end
         OP_STR: begin
            op       = OP_STR;
            alu_op   = ALU_ADDR;
            is_store = 1'b1;
         end
         OP_CONST: begin
            op     = OP_CONST;
            alu_op = ALU_PASS_IMM;
         end
         default: begin
            op = OP_NOP;
         end
      endcase
   end

   assign rf_we = (op == OP_ARITH) || (op == OP_LOGIC) || (op == OP_CONST) || (op == OP_LDR);

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         d2x.pc       <= '0;
         d2x.insn     <= '0;
         d2x.op       <= OP_NOP;
         d2x.alu_op   <= ALU_ADD;
         d2x.wsel     <= '0;
         d2x.rf_we    <= 1'b0;
         d2x.is_load  <= 1'b0;
         d2x.is_store <= 1'b0;
         d2x.rs_data  <= '0;
         d2x.rt_data  <= '0;
      end else begin
         d2x.pc       <= f2d.pc;
         d2x.insn     <= f2d.insn;
         d2x.op       <= op;
         d2x.alu_op   <= alu_op;
         d2x.wsel     <= f2d.insn[RD_MSB:RD_LSB];
         d2x.rf_we    <= rf_we;
         d2x.is_load  <= is_load;
         d2x.is_store <= is_store;
         d2x.rs_data  <= i_rs_data;
         d2x.rt_data  <= i_rt_data;
      end
   end

   // result is filled in by execute
   assign d2x.result = '0;

endmodule

`default_nettype wire

//--- lc4_regfile.sv
`default_nettype none

module lc4_regfile
   import lc4_pkg::*;
#(
   parameter int P_NUM_REGS = LC4_NUM_REGS
) (
   input  wire        gwe,
   input  wire        i_rst_n,
   input  lc4_reg_t   i_rs_sel,
   input  lc4_reg_t   i_rt_sel,
   input  lc4_reg_t   i_wsel,
   input  wire        i_we,
   input  lc4_word_t  i_wdata,
   output lc4_word_t  o_rs_data,
   output lc4_word_t  o_rt_data
);

   lc4_word_t regs [P_NUM_REGS];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < P_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wsel] <= i_wdata;
      end
   end

   // writeback in the same cycle wins over the stored value
   assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- lc4_execute.sv
`default_nettype none

module lc4_execute
   import lc4_pkg::*;
(
   input  wire       gwe,
   input  wire       i_rst_n,
   lc4_stage_if.dst  d2x,
   lc4_stage_if.src  x2m
);

   lc4_word_t imm9;
   lc4_word_t off6;
   lc4_word_t result;

   assign imm9 = {{(LC4_WORD_W-IMM9_W){d2x.insn[IMM9_W-1]}}, d2x.insn[IMM9_W-1:0]};
   assign off6 = {{(LC4_WORD_W-OFF6_W){d2x.insn[OFF6_W-1]}}, d2x.insn[OFF6_W-1:0]};

   always_comb begin
      case (d2x.alu_op)
         ALU_ADD:      result = d2x.rs_data + d2x.rt_data;
         ALU_SUB:      result = d2x.rs_data - d2x.rt_data;
         ALU_AND:      result = d2x.rs_data & d2x.rt_data;
         ALU_OR:       result = d2x.rs_data | d2x.rt_data;
         ALU_XOR:      result = d2x.rs_data ^ d2x.rt_data;
         ALU_PASS_IMM: result = imm9;
         // effective address for LDR and STR
         ALU_ADDR:     result = d2x.rs_data + off6;
         default:      result = '0;
      endcase
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x2m.pc       <= '0;
         x2m.insn     <= '0;
         x2m.op       <= OP_NOP;
         x2m.alu_op   <= ALU_ADD;
         x2m.wsel     <= '0;
         x2m.rf_we    <= 1'b0;
         x2m.is_load  <= 1'b0;
         x2m.is_store <= 1'b0;
         x2m.rs_data  <= '0;
         x2m.rt_data  <= '0;
         x2m.result   <= '0;
      end else begin
         x2m.pc       <= d2x.pc;
         x2m.insn     <= d2x.insn;
         x2m.op       <= d2x.op;
         x2m.alu_op   <= d2x.alu_op;
         x2m.wsel     <= d2x.wsel;
         x2m.rf_we    <= d2x.rf_we;
         x2m.is_load  <= d2x.is_load;
         x2m.is_store <= d2x.is_store;
         x2m.rs_data  <= d2x.rs_data;
         x2m.rt_data  <= d2x.rt_data;
         x2m.result   <= result;
      end
   end

endmodule

`default_nettype wire

//--- lc4_memory.sv
`default_nettype none

module lc4_memory
   import lc4_pkg::*;
(
   input  wire        gwe,
   input  wire        i_rst_n,
   lc4_stage_if.dst   x2m,
   lc4_stage_if.src   m2w,
   output lc4_word_t  o_dmem_addr,
   output lc4_word_t  o_dmem_towrite,
   output logic       o_dmem_we,
   input  lc4_word_t  i_cur_dmem_data
);

   logic      mem_access;
   lc4_word_t wb_data;
   lc4_word_t mem_data;

   assign mem_access = x2m.is_load || x2m.is_store;

   // data memory sees only loads and stores
   assign o_dmem_addr    = mem_access ? x2m.result : '0;
   assign o_dmem_we      = x2m.is_store;
   assign o_dmem_towrite = x2m.is_store ? x2m.rt_data : '0;

   // word moved over the data bus, for the trace
   always_comb begin
      if (x2m.is_store) begin
         mem_data = x2m.rt_data;
      end else if (x2m.is_load) begin
         mem_data = i_cur_dmem_data;
      end else begin
         mem_data = '0;
      end
   end

   assign wb_data = mem_access ? mem_data : x2m.result;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m2w.pc       <= '0;
         m2w.insn     <= '0;
         m2w.op       <= OP_NOP;
         m2w.alu_op   <= ALU_ADD;
         m2w.wsel     <= '0;
         m2w.rf_we    <= 1'b0;
         m2w.is_load  <= 1'b0;
         m2w.is_store <= 1'b0;
         m2w.rs_data  <= '0;
         m2w.rt_data  <= '0;
         m2w.result   <= '0;
      end else begin
         m2w.pc       <= x2m.pc;
         m2w.insn     <= x2m.insn;
         m2w.op       <= x2m.op;
         m2w.alu_op   <= x2m.alu_op;
         m2w.wsel     <= x2m.wsel;
         m2w.rf_we    <= x2m.rf_we;
         m2w.is_load  <= x2m.is_load;
         m2w.is_store <= x2m.is_store;
         // rs_data now carries the memory address
         m2w.rs_data  <= o_dmem_addr;
         m2w.rt_data  <= mem_data;
         m2w.result   <= wb_data;
      end
   end

endmodule

`default_nettype wire

//--- lc4_pipeline.sv
`default_nettype none

module lc4_pipeline
   import lc4_pkg::*;
#(
   parameter lc4_word_t P_RESET_PC = LC4_RESET_PC
) (
   input  wire        gwe,
   input  wire        i_rst_n,
   output lc4_word_t  o_cur_pc,
   input  lc4_word_t  i_cur_insn,
   output lc4_word_t  o_dmem_addr,
   input  lc4_word_t  i_cur_dmem_data,
   output logic       o_dmem_we,
   output lc4_word_t  o_dmem_towrite,
   output lc4_word_t  o_trace_pc,
   output lc4_word_t  o_trace_insn,
   output logic       o_trace_rf_we,
   output lc4_reg_t   o_trace_rf_wsel,
   output lc4_word_t  o_trace_rf_data,
   output logic       o_trace_dmem_we,
   output lc4_word_t  o_trace_dmem_addr,
   output lc4_word_t  o_trace_dmem_data
);

   lc4_reg_t  rs_sel;
   lc4_reg_t  rt_sel;
   lc4_word_t rs_data;
   lc4_word_t rt_data;

   lc4_stage_if f2d ();
   lc4_stage_if d2x ();
   lc4_stage_if x2m ();
   lc4_stage_if m2w ();

   lc4_fetch #(
      .P_RESET_PC (P_RESET_PC)
   ) u_fetch (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_cur_insn (i_cur_insn),
      .o_cur_pc   (o_cur_pc),
      .f2d        (f2d.src)
   );

   lc4_decode u_decode (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .f2d       (f2d.dst),
      .d2x       (d2x.src),
      .o_rs_sel  (rs_sel),
      .o_rt_sel  (rt_sel),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data)
   );

   // written from the writeback register
   lc4_regfile #(
      .P_NUM_REGS (LC4_NUM_REGS)
   ) u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .i_wsel    (m2w.wsel),
      .i_we      (m2w.rf_we),
      .i_wdata   (m2w.result),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_execute u_execute (
      .gwe     (gwe),
      .i_rst_n (i_rst_n),
      .d2x     (d2x.dst),
      .x2m     (x2m.src)
   );

   lc4_memory u_memory (
      .gwe             (gwe),
      .i_rst_n         (i_rst_n),
      .x2m             (x2m.dst),
      .m2w             (m2w.src),
      .o_dmem_addr     (o_dmem_addr),
      .o_dmem_towrite  (o_dmem_towrite),
      .o_dmem_we       (o_dmem_we),
      .i_cur_dmem_data (i_cur_dmem_data)
   );

   assign o_trace_pc        = m2w.pc;
   assign o_trace_insn      = m2w.insn;
   assign o_trace_rf_we     = m2w.rf_we;
   assign o_trace_rf_wsel   = m2w.wsel;
   assign o_trace_rf_data   = m2w.result;
   assign o_trace_dmem_we   = m2w.is_store;
   assign o_trace_dmem_addr = m2w.rs_data;
   assign o_trace_dmem_data = m2w.rt_data;

endmodule

`default_nettype wire

//--- lc4_pipeline_chk.sv
`default_nettype none

module lc4_pipeline_chk
   import lc4_pkg::*;
(
   input wire        gwe,
   input wire        i_rst_n,
   input lc4_word_t  i_cur_pc,
   input wire        i_dmem_we,
   input lc4_word_t  i_trace_pc,
   input wire        i_trace_rf_we
);

   int unsigned run_cycles;

   // edges seen since reset went away, saturating
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         run_cycles <= 0;
      end else if (run_cycles < 15) begin
         run_cycles <= run_cycles + 32'd1;
      end
   end

   pc_advances: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      (run_cycles >= 1) |-> (i_cur_pc == $past(i_cur_pc) + 16'd1)
   ) else $error("pc did not advance by one");

   trace_follows_fetch: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      (run_cycles >= LC4_PIPE_DEPTH) |-> (i_trace_pc == $past(i_cur_pc, LC4_PIPE_DEPTH))
   ) else $error("trace pc is not the pc fetched four cycles earlier");

   // the first instruction reaches memory one cycle before writeback
   no_early_store: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      (run_cycles < LC4_PIPE_DEPTH - 1) |-> !i_dmem_we
   ) else $error("data memory write while the pipeline is still empty");

   no_early_writeback: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      (run_cycles < LC4_PIPE_DEPTH) |-> !i_trace_rf_we
   ) else $error("register write while the pipeline is still empty");

endmodule

`default_nettype wire

//--- lc4_pipeline_tb.sv
`default_nettype none

module lc4_pipeline_tb
   import lc4_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int TAIL_NOPS    = 4;
   localparam int MAX_INSNS    = 128;
   localparam int NUM_COLS     = 7;
   localparam int VEC_AW       = 10;
   localparam int DMEM_AW      = 8;

   // columns of one program line
   localparam int COL_INSN      = 0;
   localparam int COL_RF_WE     = 1;
   localparam int COL_WSEL      = 2;
   localparam int COL_RF_DATA   = 3;
   localparam int COL_DMEM_WE   = 4;
   localparam int COL_DMEM_ADDR = 5;
   localparam int COL_DMEM_DATA = 6;

   logic      gwe;
   logic      i_rst_n;
   lc4_word_t i_cur_insn;
   lc4_word_t i_cur_dmem_data;
   lc4_word_t o_cur_pc;
   lc4_word_t o_dmem_addr;
   logic      o_dmem_we;
   lc4_word_t o_dmem_towrite;
   lc4_word_t o_trace_pc;
   lc4_word_t o_trace_insn;
   logic      o_trace_rf_we;
   lc4_reg_t  o_trace_rf_wsel;
   lc4_word_t o_trace_rf_data;
   logic      o_trace_dmem_we;
   lc4_word_t o_trace_dmem_addr;
   lc4_word_t o_trace_dmem_data;

   // word 0 is the instruction count, then NUM_COLS words per instruction
   lc4_word_t vec [0:(1<<VEC_AW)-1];
   lc4_word_t dmem [0:(1<<DMEM_AW)-1];
   lc4_word_t imem_off;
   int        prog_len = 0;
   logic      prog_loaded = 1'b0;
   int        num_checks = 0;
   int        num_errors = 0;

   lc4_pipeline #(
      .P_RESET_PC (LC4_RESET_PC)
   ) DUT (
      .gwe               (gwe),
      .i_rst_n           (i_rst_n),
      .o_cur_pc          (o_cur_pc),
      .i_cur_insn        (i_cur_insn),
      .o_dmem_addr       (o_dmem_addr),
      .i_cur_dmem_data   (i_cur_dmem_data),
      .o_dmem_we         (o_dmem_we),
      .o_dmem_towrite    (o_dmem_towrite),
      .o_trace_pc        (o_trace_pc),
      .o_trace_insn      (o_trace_insn),
      .o_trace_rf_we     (o_trace_rf_we),
      .o_trace_rf_wsel   (o_trace_rf_wsel),
      .o_trace_rf_data   (o_trace_rf_data),
      .o_trace_dmem_we   (o_trace_dmem_we),
      .o_trace_dmem_addr (o_trace_dmem_addr),
      .o_trace_dmem_data (o_trace_dmem_data)
   );

   bind lc4_pipeline lc4_pipeline_chk u_chk (
      .gwe           (gwe),
      .i_rst_n       (i_rst_n),
      .i_cur_pc      (o_cur_pc),
      .i_dmem_we     (o_dmem_we),
      .i_trace_pc    (o_trace_pc),
      .i_trace_rf_we (o_trace_rf_we)
   );

   // words past the end of the program read as NOP
   function automatic lc4_word_t program_field(input int k, input int col);
      logic [VEC_AW-1:0] idx;
      idx = VEC_AW'(1 + k * NUM_COLS + col);
      if (k < prog_len) begin
         return vec[idx];
      end else begin
         return '0;
      end
   endfunction

   task automatic check_word(input string name, input lc4_word_t exp_val,
                             input lc4_word_t act_val);
      num_checks++;
      if (act_val !== exp_val) begin
         num_errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
      end
   endtask

   task automatic check_reg(input string name, input lc4_reg_t exp_val, input lc4_reg_t act_val);
      num_checks++;
      if (act_val !== exp_val) begin
         num_errors++;
         $display("mismatch %s: expected %0d, actual %0d", name, exp_val, act_val);
      end
   endtask

   task automatic check_bit(input string name, input logic exp_val, input logic act_val);
      num_checks++;
      if (act_val !== exp_val) begin
         num_errors++;
         $display("mismatch %s: expected %b, actual %b", name, exp_val, act_val);
      end
   endtask

   // instruction k sits in the memory stage
   task automatic inspect_memory_stage(input int k);
      logic      exp_we;
      lc4_word_t exp_towrite;
      exp_we      = (program_field(k, COL_DMEM_WE) != '0);
      exp_towrite = exp_we ? program_field(k, COL_DMEM_DATA) : '0;
      check_bit($sformatf("insn %0d dmem_we", k), exp_we, o_dmem_we);
      check_word($sformatf("insn %0d dmem_addr", k), program_field(k, COL_DMEM_ADDR), o_dmem_addr);
      check_word($sformatf("insn %0d dmem_towrite", k), exp_towrite, o_dmem_towrite);
   endtask

   // instruction k sits in writeback
   task automatic inspect_trace(input int k);
      logic exp_rf_we;
      logic exp_dmem_we;
      exp_rf_we   = (program_field(k, COL_RF_WE) != '0);
      exp_dmem_we = (program_field(k, COL_DMEM_WE) != '0);
      check_word($sformatf("insn %0d trace pc", k), LC4_RESET_PC + lc4_word_t'(k), o_trace_pc);
      check_word($sformatf("insn %0d trace insn", k), program_field(k, COL_INSN), o_trace_insn);
      check_bit($sformatf("insn %0d trace rf_we", k), exp_rf_we, o_trace_rf_we);
      if (exp_rf_we) begin
         check_reg($sformatf("insn %0d trace rf_wsel", k),
                   lc4_reg_t'(program_field(k, COL_WSEL)), o_trace_rf_wsel);
      end
      // a store carries the stored word on the writeback data
      if (exp_rf_we || exp_dmem_we) begin
         check_word($sformatf("insn %0d trace rf_data", k),
                    program_field(k, COL_RF_DATA), o_trace_rf_data);
      end
      check_bit($sformatf("insn %0d trace dmem_we", k), exp_dmem_we, o_trace_dmem_we);
      check_word($sformatf("insn %0d trace dmem_addr", k),
                 program_field(k, COL_DMEM_ADDR), o_trace_dmem_addr);
      check_word($sformatf("insn %0d trace dmem_data", k),
                 program_field(k, COL_DMEM_DATA), o_trace_dmem_data);
   endtask

   initial begin
      gwe = 1'b0;
      forever #(CLK_PERIOD / 2) gwe = ~gwe;
   end

   // instruction memory answers the pc in the same cycle
   always_comb begin
      imem_off   = o_cur_pc - LC4_RESET_PC;
      i_cur_insn = program_field(int'(imem_off), COL_INSN);
   end

   always_comb begin
      i_cur_dmem_data = dmem[o_dmem_addr[DMEM_AW-1:0]];
   end

   always @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int a = 0; a < (1 << DMEM_AW); a++) begin
            dmem[DMEM_AW'(a)] <= '0;
         end
      end else if (o_dmem_we) begin
         dmem[o_dmem_addr[DMEM_AW-1:0]] <= o_dmem_towrite;
      end
   end

   initial begin
      i_rst_n <= 1'b0;
      $readmemh("lc4_program_input.hex", vec);
      prog_len = int'(vec[0]);
      if (prog_len < 1 || prog_len > MAX_INSNS) begin
         num_errors++;
         $display("error: program file gives %0d instructions, expected 1 to %0d",
                  prog_len, MAX_INSNS);
         prog_len = 0;
      end
      prog_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge gwe);
      i_rst_n <= 1'b1;
      // first instruction reaches the memory stage after three edges
      repeat (LC4_PIPE_DEPTH - 1) @(posedge gwe);
      for (int k = 0; k <= prog_len + TAIL_NOPS; k++) begin
         @(negedge gwe);
         inspect_memory_stage(k);
         if (k > 0) begin
            inspect_trace(k - 1);
         end
         @(posedge gwe);
      end
      $display("checks: %0d, errors: %0d", num_checks, num_errors);
      if (num_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      wait (prog_loaded);
      #((prog_len + LC4_PIPE_DEPTH + 10) * CLK_PERIOD * 2);
      $display("error: timeout, the trace checks did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- lc4_program_input.hex
// first word: instruction count; then one instruction per line
// insn rf_we wsel rf_data dmem_we dmem_addr dmem_data
10
9219 1 1 0019 0 0000 0000
95FD 1 2 FFFD 0 0000 0000
96F0 1 3 00F0 0 0000 0000
0000 0 0 0000 0 0000 0000
1842 1 4 0016 0 0000 0000
1AD1 1 5 00D7 0 0000 0000
5CC2 1 6 00F0 0 0000 0000
5E53 1 7 00F9 0 0000 0000
511A 1 0 FFEB 0 0000 0000
7AF8 0 5 00D7 1 00E8 00D7
7C47 0 6 00F0 1 0020 00F0
62F8 1 1 00D7 0 00E8 00D7
1407 1 2 00E4 0 0000 0000
670A 1 3 00F0 0 0020 00F0
9B00 1 5 FF00 0 0000 0000
1FFF 0 7 0000 0 0000 0000

//--- lc4_pipeline.f
lc4_pkg.sv
lc4_stage_if.sv
lc4_fetch.sv
lc4_decode.sv
lc4_regfile.sv
lc4_execute.sv
lc4_memory.sv
lc4_pipeline.sv
lc4_pipeline_chk.sv
lc4_pipeline_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lc4_pipeline_tb \
   -f lc4_pipeline.f -o lc4_sim || exit 1
./obj_dir/lc4_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
